/* verilog/undo_pkg.sv */
package undo_pkg;

   // ##############################
   // sizes
   // ##############################
   localparam int n_cores          = 4;
   localparam int n_contexts       = 4;
   localparam int log_slots        = 16;
   localparam int entries_per_slot = 8;
   localparam int addr_w           = 32;
   localparam int data_w           = 32;
   localparam int store_words      = log_slots * entries_per_slot;  // 128

   // ##############################
   // types
   // ##############################
   typedef logic [$clog2(log_slots)-1:0]        slot_t;
   typedef logic [$clog2(entries_per_slot)-1:0] entry_id_t;
   typedef logic [$clog2(entries_per_slot):0]   entry_count_t;  // 1..8
   typedef logic [$clog2(n_cores)-1:0]          core_sel_t;
   typedef logic [$clog2(n_contexts)-1:0]       ctx_id_t;       // also the write id
   typedef logic [addr_w-1:0]                   log_addr_t;
   typedef logic [data_w-1:0]                   log_data_t;

   // lowest set bit of a request vector
   // cores and contexts are both four wide, so one encoder serves both
   function automatic core_sel_t lowest_bit(input logic [n_cores-1:0] vec);
      core_sel_t idx;
      idx = '0;
      for (int i = n_cores - 1; i >= 0; i--) begin
         if (vec[i]) begin
            idx = core_sel_t'(i);
         end
      end
      return idx;
   endfunction

endpackage

/* verilog/log_arbiter.sv */
`timescale 1ns/1ns

module log_arbiter (
   input  logic                                          clk,
   input  logic                                          rstn,
   input  logic               [undo_pkg::n_cores-1:0]    log_valid,
   input  undo_pkg::entry_id_t [undo_pkg::n_cores-1:0]   log_id,
   input  undo_pkg::log_addr_t [undo_pkg::n_cores-1:0]   log_addr,
   input  undo_pkg::log_data_t [undo_pkg::n_cores-1:0]   log_data,
   input  undo_pkg::slot_t    [undo_pkg::n_cores-1:0]    log_slot,
   output logic               [undo_pkg::n_cores-1:0]    log_ready,
   output logic                                          sel_valid,
   output undo_pkg::slot_t                               sel_slot,
   output undo_pkg::entry_id_t                           sel_id,
   output undo_pkg::log_addr_t                           sel_addr,
   output undo_pkg::log_data_t                           sel_data
);

   undo_pkg::core_sel_t sel_core;

   // ##############################
   // fixed priority, core 0 first
   // ##############################
   assign sel_core  = undo_pkg::lowest_bit(log_valid);
   assign sel_valid = |log_valid;

   assign sel_slot = log_slot[sel_core];
   assign sel_id   = log_id[sel_core];
   assign sel_addr = log_addr[sel_core];
   assign sel_data = log_data[sel_core];

   // store always takes the entry, so ready follows the grant
   always_comb begin
      log_ready = '0;
      if (sel_valid) begin
         log_ready[sel_core] = 1'b1;
      end
   end

endmodule

/* verilog/undo_store.sv */
`timescale 1ns/1ns

module undo_store (
   input  logic                clk,
   // write side, from the arbiter
   input  logic                sel_valid,
   input  undo_pkg::slot_t     sel_slot,
   input  undo_pkg::entry_id_t sel_id,
   input  undo_pkg::log_addr_t sel_addr,
   input  undo_pkg::log_data_t sel_data,
   // entry count lookup for the dispatcher
   input  undo_pkg::slot_t     last_slot,
   output undo_pkg::entry_count_t last_count,
   // restore read side
   input  undo_pkg::slot_t     rd_slot,
   input  undo_pkg::entry_id_t rd_id,
   output undo_pkg::log_addr_t rd_addr,
   output undo_pkg::log_data_t rd_data
);

   localparam int idx_w = $bits(undo_pkg::slot_t) + $bits(undo_pkg::entry_id_t);

   undo_pkg::log_addr_t addr_mem [undo_pkg::store_words];
   undo_pkg::log_data_t data_mem [undo_pkg::store_words];
   undo_pkg::entry_id_t last_id  [undo_pkg::log_slots];

   logic [idx_w-1:0] wr_idx;
   logic [idx_w-1:0] rd_idx;

   assign wr_idx = {sel_slot, sel_id};  // slot * 8 + entry
   assign rd_idx = {rd_slot, rd_id};

   // ##############################
   // log memories
   // ##############################
   always_ff @(posedge clk) begin
      if (sel_valid) begin
         addr_mem[wr_idx] <= sel_addr;
         data_mem[wr_idx] <= sel_data;
      end
      rd_addr <= addr_mem[rd_idx];
      rd_data <= data_mem[rd_idx];
   end

   // last index written per slot
   always_ff @(posedge clk) begin
      if (sel_valid) begin
         last_id[sel_slot] <= sel_id;
      end
   end

   assign last_count = undo_pkg::entry_count_t'(last_id[last_slot])
                       + undo_pkg::entry_count_t'(1);

endmodule

/* verilog/restore_dispatch.sv */
`timescale 1ns/1ns

module restore_dispatch (
   input  logic                                  clk,
   input  logic                                  rstn,
   // restore request
   input  logic                                  restore_valid,
   input  undo_pkg::slot_t                       restore_slot,
   output logic                                  restore_ready,
   // context side
   input  logic [undo_pkg::n_contexts-1:0]       ctx_free,
   output undo_pkg::slot_t                       last_slot,
   output logic [undo_pkg::n_contexts-1:0]       start,
   output undo_pkg::slot_t                       start_slot,
   output undo_pkg::entry_count_t                start_count,
   input  undo_pkg::entry_count_t                last_count
);

   undo_pkg::ctx_id_t free_ctx;
   logic              accept;

   // ##############################
   // context allocation
   // ##############################
   assign free_ctx      = undo_pkg::ctx_id_t'(undo_pkg::lowest_bit(ctx_free));
   assign restore_ready = |ctx_free;
   assign accept        = restore_valid && restore_ready;

   always_comb begin
      start = '0;
      if (accept) begin
         start[free_ctx] = 1'b1;  // context loads at this edge
      end
   end

   // count comes straight from the store's last-index table
   assign last_slot   = restore_slot;
   assign start_slot  = restore_slot;
   assign start_count = last_count;

endmodule

/* verilog/restore_context.sv */
`timescale 1ns/1ns

module restore_context #(
   parameter int ctx_index = 0
) (
   input  logic                   clk,
   input  logic                   rstn,
   // from the dispatcher
   input  logic                   start,
   input  undo_pkg::slot_t        start_slot,
   input  undo_pkg::entry_count_t start_count,
   // to the write sequencer
   output logic                   pending,
   output undo_pkg::slot_t        ctx_slot,
   output undo_pkg::entry_count_t ctx_count,
   output logic                   ctx_free,
   input  logic                   finish,
   // write acknowledges
   input  logic                   mem_bvalid,
   input  undo_pkg::ctx_id_t      mem_bid,
   // done report
   output logic                   done_valid,
   output undo_pkg::slot_t        done_slot,
   input  logic                   done_ready
);

   typedef enum logic [1:0] {
      ctx_idle,
      ctx_writing,
      ctx_wait_ack,
      ctx_done
   } ctx_state_t;

   ctx_state_t             state;
   undo_pkg::entry_count_t acks_left;
   logic                   ack_hit;

   assign ack_hit = mem_bvalid && (mem_bid == undo_pkg::ctx_id_t'(ctx_index));

   // ##############################
   // restore FSM
   // ##############################
   always_ff @(posedge clk) begin
      if (!rstn) begin
         state <= ctx_idle;
      end else begin
         case (state)
            ctx_idle:     if (start) state <= ctx_writing;
            ctx_writing:  if (finish) state <= ctx_wait_ack;
            ctx_wait_ack: if (acks_left == '0) state <= ctx_done;
            ctx_done:     if (done_ready) state <= ctx_idle;
            default:      state <= ctx_idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (start && state == ctx_idle) begin
         ctx_slot  <= start_slot;
         ctx_count <= start_count;
         acks_left <= start_count;  // one ack per entry written
      end else if (ack_hit) begin
         acks_left <= acks_left - undo_pkg::entry_count_t'(1);
      end
   end

   assign pending    = (state == ctx_writing);
   assign ctx_free   = (state == ctx_idle);
   assign done_valid = (state == ctx_done);
   assign done_slot  = ctx_slot;

endmodule

/* verilog/write_sequencer.sv */
`timescale 1ns/1ns

module write_sequencer (
   input  logic                                               clk,
   input  logic                                               rstn,
   // contexts
   input  logic                   [undo_pkg::n_contexts-1:0]  pending,
   input  undo_pkg::slot_t        [undo_pkg::n_contexts-1:0]  ctx_slot,
   input  undo_pkg::entry_count_t [undo_pkg::n_contexts-1:0]  ctx_count,
   output logic                   [undo_pkg::n_contexts-1:0]  finish,
   // store read port
   output undo_pkg::slot_t                                    rd_slot,
   output undo_pkg::entry_id_t                                rd_id,
   input  undo_pkg::log_addr_t                                rd_addr,
   input  undo_pkg::log_data_t                                rd_data,
   // memory write port
   output logic                                               mem_wvalid,
   output undo_pkg::log_addr_t                                mem_waddr,
   output undo_pkg::log_data_t                                mem_wdata,
   output undo_pkg::ctx_id_t                                  mem_wid,
   input  logic                                               mem_wready
);

   typedef enum logic [1:0] {
      seq_idle,
      seq_read,
      seq_write
   } seq_state_t;

   seq_state_t          state;
   undo_pkg::ctx_id_t   cur_ctx;
   undo_pkg::entry_id_t cur_id;
   logic                last_entry;
   logic                wr_accept;

   assign last_entry = (undo_pkg::entry_count_t'(cur_id) + undo_pkg::entry_count_t'(1))
                       == ctx_count[cur_ctx];
   assign wr_accept  = (state == seq_write) && mem_wready;

   // ##############################
   // entry walk
   // ##############################
   always_ff @(posedge clk) begin
      if (!rstn) begin
         state   <= seq_idle;
         cur_ctx <= '0;
         cur_id  <= '0;
      end else begin
         case (state)
            seq_idle: begin
               if (|pending) begin
                  cur_ctx <= undo_pkg::ctx_id_t'(undo_pkg::lowest_bit(pending));
                  cur_id  <= '0;
                  state   <= seq_read;
               end
            end
            seq_read: state <= seq_write;  // store read lands here
            seq_write: begin
               if (mem_wready) begin
                  if (last_entry) begin
                     state <= seq_idle;
                  end else begin
                     cur_id <= cur_id + undo_pkg::entry_id_t'(1);
                     state  <= seq_read;
                  end
               end
            end
            default: state <= seq_idle;
         endcase
      end
   end

   // read address stays put during write, so the payload holds
   assign rd_slot = ctx_slot[cur_ctx];
   assign rd_id   = cur_id;

   assign mem_wvalid = (state == seq_write);
   assign mem_waddr  = rd_addr;
   assign mem_wdata  = rd_data;
   assign mem_wid    = cur_ctx;

   always_comb begin
      finish = '0;
      if (wr_accept && last_entry) begin
         finish[cur_ctx] = 1'b1;
      end
   end

endmodule

/* verilog/undo_log_top.sv */
`timescale 1ns/1ns

module undo_log_top (
   input  logic                                            clk,
   input  logic                                            rstn,
   // log entries from the cores
   input  logic                [undo_pkg::n_cores-1:0]     log_valid,
   input  undo_pkg::entry_id_t [undo_pkg::n_cores-1:0]     log_id,
   input  undo_pkg::log_addr_t [undo_pkg::n_cores-1:0]     log_addr,
   input  undo_pkg::log_data_t [undo_pkg::n_cores-1:0]     log_data,
   input  undo_pkg::slot_t     [undo_pkg::n_cores-1:0]     log_slot,
   output logic                [undo_pkg::n_cores-1:0]     log_ready,
   // restore requests
   input  logic                                            restore_valid,
   input  undo_pkg::slot_t                                 restore_slot,
   output logic                                            restore_ready,
   // memory write port
   output logic                                            mem_wvalid,
   output undo_pkg::log_addr_t                             mem_waddr,
   output undo_pkg::log_data_t                             mem_wdata,
   output undo_pkg::ctx_id_t                               mem_wid,
   input  logic                                            mem_wready,
   input  logic                                            mem_bvalid,
   input  undo_pkg::ctx_id_t                               mem_bid,
   // done reports
   output logic                [undo_pkg::n_contexts-1:0]  done_valid,
   output undo_pkg::slot_t     [undo_pkg::n_contexts-1:0]  done_slot,
   input  logic                [undo_pkg::n_contexts-1:0]  done_ready
);

   logic                   sel_valid;
   undo_pkg::slot_t        sel_slot;
   undo_pkg::entry_id_t    sel_id;
   undo_pkg::log_addr_t    sel_addr;
   undo_pkg::log_data_t    sel_data;
   undo_pkg::slot_t        last_slot;
   undo_pkg::entry_count_t last_count;
   undo_pkg::slot_t        rd_slot;
   undo_pkg::entry_id_t    rd_id;
   undo_pkg::log_addr_t    rd_addr;
   undo_pkg::log_data_t    rd_data;
   logic                   [undo_pkg::n_contexts-1:0] start;
   undo_pkg::slot_t        start_slot;
   undo_pkg::entry_count_t start_count;
   logic                   [undo_pkg::n_contexts-1:0] ctx_free;
   logic                   [undo_pkg::n_contexts-1:0] pending;
   logic                   [undo_pkg::n_contexts-1:0] finish;
   undo_pkg::slot_t        [undo_pkg::n_contexts-1:0] ctx_slot;
   undo_pkg::entry_count_t [undo_pkg::n_contexts-1:0] ctx_count;

   log_arbiter u_log_arbiter (
      .clk(clk), .rstn(rstn),
      .log_valid(log_valid), .log_id(log_id), .log_addr(log_addr),
      .log_data(log_data), .log_slot(log_slot), .log_ready(log_ready),
      .sel_valid(sel_valid), .sel_slot(sel_slot), .sel_id(sel_id),
      .sel_addr(sel_addr), .sel_data(sel_data)
   );

   undo_store u_undo_store (
      .clk(clk),
      .sel_valid(sel_valid), .sel_slot(sel_slot), .sel_id(sel_id),
      .sel_addr(sel_addr), .sel_data(sel_data),
      .last_slot(last_slot), .last_count(last_count),
      .rd_slot(rd_slot), .rd_id(rd_id), .rd_addr(rd_addr), .rd_data(rd_data)
   );

   restore_dispatch u_restore_dispatch (
      .clk(clk), .rstn(rstn),
      .restore_valid(restore_valid), .restore_slot(restore_slot),
      .restore_ready(restore_ready), .ctx_free(ctx_free), .last_slot(last_slot),
      .start(start), .start_slot(start_slot), .start_count(start_count),
      .last_count(last_count)
   );

   // ##############################
   // restore contexts
   // ##############################
   for (genvar c = 0; c < undo_pkg::n_contexts; c++) begin : g_ctx
      restore_context #(.ctx_index(c)) u_restore_context (
         .clk(clk), .rstn(rstn),
         .start(start[c]), .start_slot(start_slot), .start_count(start_count),
         .pending(pending[c]), .ctx_slot(ctx_slot[c]), .ctx_count(ctx_count[c]),
         .ctx_free(ctx_free[c]), .finish(finish[c]),
         .mem_bvalid(mem_bvalid), .mem_bid(mem_bid),
         .done_valid(done_valid[c]), .done_slot(done_slot[c]),
         .done_ready(done_ready[c])
      );
   end

   write_sequencer u_write_sequencer (
      .clk(clk), .rstn(rstn),
      .pending(pending), .ctx_slot(ctx_slot), .ctx_count(ctx_count),
      .finish(finish), .rd_slot(rd_slot), .rd_id(rd_id),
      .rd_addr(rd_addr), .rd_data(rd_data),
      .mem_wvalid(mem_wvalid), .mem_waddr(mem_waddr), .mem_wdata(mem_wdata),
      .mem_wid(mem_wid), .mem_wready(mem_wready)
   );

endmodule

/* tests/undo_log_checker.sv */
`timescale 1ns/1ns

module undo_log_checker (
   input  logic                                            clk,
   input  logic                                            rstn,
   input  logic                [undo_pkg::n_cores-1:0]     log_valid,
   input  undo_pkg::entry_id_t [undo_pkg::n_cores-1:0]     log_id,
   input  undo_pkg::log_addr_t [undo_pkg::n_cores-1:0]     log_addr,
   input  undo_pkg::log_data_t [undo_pkg::n_cores-1:0]     log_data,
   input  undo_pkg::slot_t     [undo_pkg::n_cores-1:0]     log_slot,
   input  logic                [undo_pkg::n_cores-1:0]     log_ready,
   input  logic                                            restore_valid,
   input  undo_pkg::slot_t                                 restore_slot,
   input  logic                                            restore_ready,
   input  logic                                            mem_wvalid,
   input  undo_pkg::log_addr_t                             mem_waddr,
   input  undo_pkg::log_data_t                             mem_wdata,
   input  undo_pkg::ctx_id_t                               mem_wid,
   input  logic                                            mem_wready,
   input  logic                                            mem_bvalid,
   input  undo_pkg::ctx_id_t                               mem_bid,
   input  logic                [undo_pkg::n_contexts-1:0]  done_valid,
   input  undo_pkg::slot_t     [undo_pkg::n_contexts-1:0]  done_slot,
   input  logic                [undo_pkg::n_contexts-1:0]  done_ready,
   output int                                              arb_errors,
   output int                                              write_errors,
   output int                                              done_errors,
   output int                                              cap_errors
);

   localparam int n_ctx = undo_pkg::n_contexts;

   undo_pkg::log_addr_t shadow_addr [undo_pkg::store_words];
   undo_pkg::log_data_t shadow_data [undo_pkg::store_words];
   int                  shadow_last [undo_pkg::log_slots];  // last logged index per slot
   logic [n_ctx-1:0]    busy;                               // model of the context pool
   logic [n_ctx-1:0]    done_seen;
   undo_pkg::slot_t     exp_slot    [n_ctx];
   int                  exp_count   [n_ctx];
   int                  next_idx    [n_ctx];
   int                  outstanding [n_ctx];                // writes still waiting for an ack
   int                  reset_edges = 0;
   int                  arb_count   = 0;
   int                  write_count = 0;
   int                  done_count  = 0;
   int                  cap_count   = 0;

   assign arb_errors   = arb_count;
   assign write_errors = write_count;
   assign done_errors  = done_count;
   assign cap_errors   = cap_count;

   function automatic logic [undo_pkg::n_cores-1:0] lowest_set(
      input logic [undo_pkg::n_cores-1:0] vec);
      return vec & (~vec + 1'b1);  // two's complement isolates the lowest one
   endfunction

   // address and data that a restore must write for one entry of a slot
   function automatic logic [63:0] expected_write(input undo_pkg::slot_t slot, input int idx);
      int pos;
      pos = int'(slot) * undo_pkg::entries_per_slot + idx;
      return {shadow_addr[pos], shadow_data[pos]};
   endfunction

   function automatic int first_free(input logic [n_ctx-1:0] used);
      int found;
      found = -1;
      for (int i = n_ctx - 1; i >= 0; i--) begin
         if (!used[i]) found = i;
      end
      return found;
   endfunction

   task automatic show_mismatch(input string test, input logic [63:0] expected,
                                input logic [63:0] actual);
      $display("Error %s: expected %0h actual %0h at %0t", test, expected, actual, $time);
   endtask

   // ##############################
   // per-edge comparison
   // ##############################
   always @(posedge clk) begin
      int          c;
      int          pos;
      logic [63:0] exp_word;
      if (!rstn) begin
         if (reset_edges > 0 && {restore_ready, mem_wvalid, done_valid} !== 6'b100000) begin
            show_mismatch("reset", 64'b100000, {restore_ready, mem_wvalid, done_valid});
            cap_count++;
         end
         reset_edges++;
         busy      = '0;
         done_seen = '0;
      end else begin
         if (log_ready !== lowest_set(log_valid)) begin
            show_mismatch("arbitration", lowest_set(log_valid), log_ready);
            arb_count++;
         end
         for (int k = 0; k < undo_pkg::n_cores; k++) begin
            if (log_valid[k] && log_ready[k]) begin
               pos = int'(log_slot[k]) * undo_pkg::entries_per_slot + int'(log_id[k]);
               shadow_addr[pos]         = log_addr[k];
               shadow_data[pos]         = log_data[k];
               shadow_last[log_slot[k]] = int'(log_id[k]);
            end
         end
         if (restore_ready !== (busy != '1)) begin
            show_mismatch("capacity", busy != '1, restore_ready);
            cap_count++;
         end
         if (restore_valid && restore_ready) begin
            c = first_free(busy);
            if (c < 0) begin
               $display("restore of slot %0d accepted while all contexts were busy", restore_slot);
               cap_count++;
            end else begin
               busy[c]        = 1'b1;
               done_seen[c]   = 1'b0;
               exp_slot[c]    = restore_slot;
               exp_count[c]   = shadow_last[restore_slot] + 1;
               next_idx[c]    = 0;
               outstanding[c] = 0;
            end
         end
         // a write or ack in the same cycle as done counts as still open
         for (int k = 0; k < n_ctx; k++) begin
            if (done_valid[k] && !done_seen[k]) begin
               done_seen[k] = 1'b1;
               if (!busy[k]) begin
                  $display("context %0d reported done without a restore in progress", k);
                  done_count++;
               end else begin
                  if (next_idx[k] != exp_count[k]) begin
                     $display("context %0d reported done after %0d of %0d writes",
                              k, next_idx[k], exp_count[k]);
                     done_count++;
                  end
                  if (outstanding[k] != 0) begin
                     $display("context %0d reported done with %0d acknowledges outstanding",
                              k, outstanding[k]);
                     done_count++;
                  end
                  if (done_slot[k] !== exp_slot[k]) begin
                     show_mismatch("completion", exp_slot[k], done_slot[k]);
                     done_count++;
                  end
               end
            end
            if (done_valid[k] && done_ready[k]) begin
               busy[k]      = 1'b0;  // context free again from the next edge
               done_seen[k] = 1'b0;
            end
         end
         if (mem_wvalid && mem_wready) begin
            c = int'(mem_wid);
            if (!busy[c] || next_idx[c] >= exp_count[c]) begin
               $display("write to %0h with id %0d matches no expected restore entry",
                        mem_waddr, c);
               write_count++;
            end else begin
               exp_word = expected_write(exp_slot[c], next_idx[c]);
               if ({mem_waddr, mem_wdata} !== exp_word) begin
                  show_mismatch("restore_write", exp_word, {mem_waddr, mem_wdata});
                  write_count++;
               end
               next_idx[c]++;
               outstanding[c]++;
            end
         end
         if (mem_bvalid) begin
            c = int'(mem_bid);
            if (outstanding[c] == 0) begin
               $display("acknowledge with id %0d but no write of that context is open", c);
               done_count++;
            end else begin
               outstanding[c]--;
            end
         end
      end
   end

endmodule

/* tests/tb_undo_log.sv */
`timescale 1ns/1ns

module tb_undo_log;

   localparam int n_restores     = 24;
   localparam int used_slots     = 12;
   localparam int slots_per_core = used_slots / undo_pkg::n_cores;

   logic                                            clk;
   logic                                            rstn;
   logic                [undo_pkg::n_cores-1:0]     log_valid;
   undo_pkg::entry_id_t [undo_pkg::n_cores-1:0]     log_id;
   undo_pkg::log_addr_t [undo_pkg::n_cores-1:0]     log_addr;
   undo_pkg::log_data_t [undo_pkg::n_cores-1:0]     log_data;
   undo_pkg::slot_t     [undo_pkg::n_cores-1:0]     log_slot;
   logic                [undo_pkg::n_cores-1:0]     log_ready;
   logic                                            restore_valid;
   undo_pkg::slot_t                                 restore_slot;
   logic                                            restore_ready;
   logic                                            mem_wvalid;
   undo_pkg::log_addr_t                             mem_waddr;
   undo_pkg::log_data_t                             mem_wdata;
   undo_pkg::ctx_id_t                               mem_wid;
   logic                                            mem_wready;
   logic                                            mem_bvalid;
   undo_pkg::ctx_id_t                               mem_bid;
   logic                [undo_pkg::n_contexts-1:0]  done_valid;
   undo_pkg::slot_t     [undo_pkg::n_contexts-1:0]  done_slot;
   logic                [undo_pkg::n_contexts-1:0]  done_ready;
   int                                              arb_errors;
   int                                              write_errors;
   int                                              done_errors;
   int                                              cap_errors;

   logic [31:0]                   lfsr;
   int                            fill_count [used_slots];
   int                            core_slot  [undo_pkg::n_cores];  // which of its own slots
   int                            core_entry [undo_pkg::n_cores];
   logic [undo_pkg::n_cores-1:0]  log_taken;
   logic                          restore_taken;
   logic [undo_pkg::log_slots-1:0] slot_busy;
   logic                          fill_done = 1'b0;
   int                            fill_total = 0;
   int                            issued = 0;
   int                            restored = 0;
   int                            cycle = 0;
   int                            limit_cycles = 0;
   int                            ack_due [$];
   undo_pkg::ctx_id_t             ack_id [$];

   undo_log_top u_undo_log_top (
      .clk(clk), .rstn(rstn),
      .log_valid(log_valid), .log_id(log_id), .log_addr(log_addr), .log_data(log_data),
      .log_slot(log_slot), .log_ready(log_ready),
      .restore_valid(restore_valid), .restore_slot(restore_slot),
      .restore_ready(restore_ready),
      .mem_wvalid(mem_wvalid), .mem_waddr(mem_waddr), .mem_wdata(mem_wdata),
      .mem_wid(mem_wid), .mem_wready(mem_wready), .mem_bvalid(mem_bvalid), .mem_bid(mem_bid),
      .done_valid(done_valid), .done_slot(done_slot), .done_ready(done_ready)
   );

   undo_log_checker u_checker (
      .clk(clk), .rstn(rstn),
      .log_valid(log_valid), .log_id(log_id), .log_addr(log_addr), .log_data(log_data),
      .log_slot(log_slot), .log_ready(log_ready),
      .restore_valid(restore_valid), .restore_slot(restore_slot),
      .restore_ready(restore_ready),
      .mem_wvalid(mem_wvalid), .mem_waddr(mem_waddr), .mem_wdata(mem_wdata),
      .mem_wid(mem_wid), .mem_wready(mem_wready), .mem_bvalid(mem_bvalid), .mem_bid(mem_bid),
      .done_valid(done_valid), .done_slot(done_slot), .done_ready(done_ready),
      .arb_errors(arb_errors), .write_errors(write_errors),
      .done_errors(done_errors), .cap_errors(cap_errors)
   );

   initial clk = 1'b0;
   always #20 clk = ~clk;

   // galois form, x^32 + x^22 + x^2 + x + 1
   function automatic logic lfsr_bit();
      logic out;
      out  = lfsr[0];
      lfsr = lfsr >> 1;
      if (out) lfsr = lfsr ^ 32'h8020_0003;
      return out;
   endfunction

   function automatic logic [31:0] random_bits(input int n);
      logic [31:0] val;
      val = '0;
      for (int i = 0; i < n; i++) val = {val[30:0], lfsr_bit()};
      return val;
   endfunction

   function automatic undo_pkg::slot_t pick_free_slot();
      int s;
      do begin
         s = int'(random_bits(4));
      end while (s >= used_slots || slot_busy[s]);
      return undo_pkg::slot_t'(s);
   endfunction

   // ##############################
   // edge sampling
   // ##############################
   task automatic sample_handshakes();
      int slot;
      cycle++;
      log_taken     = log_valid & log_ready;
      restore_taken = restore_valid && restore_ready;
      for (int c = 0; c < undo_pkg::n_cores; c++) begin
         if (log_taken[c]) begin
            slot = core_slot[c] * undo_pkg::n_cores + c;
            core_entry[c]++;
            if (core_entry[c] == fill_count[slot]) begin
               core_entry[c] = 0;
               core_slot[c]++;
            end
         end
      end
      if (restore_taken) begin
         slot_busy[restore_slot] = 1'b1;
         issued++;
      end
      for (int c = 0; c < undo_pkg::n_contexts; c++) begin
         if (done_valid[c] && done_ready[c]) begin
            slot_busy[done_slot[c]] = 1'b0;
            restored++;
         end
      end
      if (mem_wvalid && mem_wready) begin
         ack_due.push_back(cycle + int'(random_bits(3)));  // seen 1 to 8 edges later
         ack_id.push_back(mem_wid);
      end
   endtask

   // each core owns slots c, c+4 and c+8 and logs their entries in index order
   task automatic present_log_entries();
      logic all_idle;
      all_idle = 1'b1;
      for (int c = 0; c < undo_pkg::n_cores; c++) begin
         if (log_taken[c]) log_valid[c] = 1'b0;
         if (!log_valid[c] && core_slot[c] < slots_per_core && lfsr_bit()) begin
            log_valid[c] = 1'b1;
            log_slot[c]  = undo_pkg::slot_t'(core_slot[c] * undo_pkg::n_cores + c);
            log_id[c]    = undo_pkg::entry_id_t'(core_entry[c]);
            log_addr[c]  = random_bits(32);
            log_data[c]  = random_bits(32);
         end
         if (log_valid[c] || core_slot[c] < slots_per_core) all_idle = 1'b0;
      end
      fill_done = all_idle;
   endtask

   task automatic request_restores();
      if (restore_taken) restore_valid = 1'b0;
      if (fill_done && !restore_valid && issued < n_restores && lfsr_bit()) begin
         restore_slot  = pick_free_slot();
         restore_valid = 1'b1;
      end
   endtask

   task automatic model_memory();
      int i;
      mem_bvalid = 1'b0;
      i = 0;
      while (i < ack_due.size() && !mem_bvalid) begin
         if (ack_due[i] <= cycle) begin
            mem_bvalid = 1'b1;
            mem_bid    = ack_id[i];
            ack_due.delete(i);
            ack_id.delete(i);
         end
         i++;
      end
      mem_wready = lfsr_bit();
      for (int c = 0; c < undo_pkg::n_contexts; c++) done_ready[c] = lfsr_bit();
   endtask

   // ##############################
   // main sequence
   // ##############################
   initial begin
      lfsr          = 32'h709c51d3;
      rstn          = 1'b0;
      log_valid     = '0;
      log_id        = '0;
      log_addr      = '0;
      log_data      = '0;
      log_slot      = '0;
      restore_valid = 1'b0;
      restore_slot  = '0;
      mem_wready    = 1'b0;
      mem_bvalid    = 1'b0;
      mem_bid       = '0;
      done_ready    = '0;
      slot_busy     = '0;
      log_taken     = '0;
      restore_taken = 1'b0;
      for (int c = 0; c < undo_pkg::n_cores; c++) begin
         core_slot[c]  = 0;
         core_entry[c] = 0;
      end
      for (int s = 0; s < used_slots; s++) begin
         fill_count[s] = int'(random_bits(3)) + 1;  // 1..8 entries per task
         fill_total    = fill_total + fill_count[s];
      end
      limit_cycles = (fill_total + n_restores) * 40;
      repeat (5) @(posedge clk);
      #2 rstn = 1'b1;
      while (!(fill_done && restored == n_restores)) begin
         @(posedge clk);
         sample_handshakes();
         #2;
         present_log_entries();
         request_restores();
         model_memory();
      end
      repeat (10) @(posedge clk);
      $display("errors: arbitration %0d, restore_write %0d, completion %0d, capacity %0d",
               arb_errors, write_errors, done_errors, cap_errors);
      if (arb_errors + write_errors + done_errors + cap_errors == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

   // watchdog
   initial begin
      wait (limit_cycles > 0);
      repeat (limit_cycles) @(posedge clk);
      $display("timeout after %0d cycles, %0d of %0d restores reported done",
               limit_cycles, restored, n_restores);
      $display("errors: arbitration %0d, restore_write %0d, completion %0d, capacity %0d",
               arb_errors, write_errors, done_errors, cap_errors);
      $display("ERRORS FOUND");
      $finish;
   end

endmodule

/* undo_log_top.f */
verilog/undo_pkg.sv
verilog/log_arbiter.sv
verilog/undo_store.sv
verilog/restore_dispatch.sv
verilog/restore_context.sv
verilog/write_sequencer.sv
verilog/undo_log_top.sv
tests/undo_log_checker.sv
tests/tb_undo_log.sv
